// File: verification/l1i_vectors.txt
// op addr expected
// op 0 fetch, 1 flush, f end; expected 1 hit, 0 miss
0 0000124 0
0 0000127 1
0 0000A08 0
0 0000B09 0
0 0000A0A 1
0 0000C0B 0
0 0000A08 1
0 0000B09 0
0 000300C 0
0 0004001 0
0 000300D 1
0 0004002 1
0 0000125 1
1 0000000 0
0 0000126 0
0 0000A09 0
0 0000A0B 1
0 ABCDEF3 0
0 ABCDEF0 1
0 1234566 0
0 0000124 1
f 0000000 0

// File: sim.f
+incdir+include
rtl/icache_types_pkg.sv
rtl/l2_bus_pkg.sv
rtl/l1i_controller.sv
rtl/l1i_data_array.sv
rtl/l1i_cache_top.sv
verification/l2_mem_model.sv
verification/l1i_assert.sv
verification/l1i_tb.sv

// File: run_sim.sh
#!/bin/bash
# build the cache testbench with Verilator and run it into sim.log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f sim.f --top-module l1i_tb -o l1i_sim \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/l1i_sim > sim.log 2>&1 \
    || { echo "simulator exited with an error, see sim.log"; exit 1; }

grep -q "SIMULATION FAILED" sim.log && { echo "test failed, see sim.log"; exit 1; }
grep -q "SIMULATION PASSED" sim.log && echo "test passed" \
    || { echo "no result found in sim.log"; exit 1; }

// File: verification/l1i_tb.sv
`include "icache_macros.svh"

module l1i_tb
    import icache_types_pkg::*, l2_bus_pkg::*;
;

    localparam int MAX_VEC = 64;

    logic        clk;
    logic        nrst;
    logic        read;
    fetch_addr_t addr;
    logic        flush;
    logic        stall;
    instr_t      instr;
    logic        instr_valid;
    logic        miss;
    logic        l2_read;
    l2_req_t     l2_req;
    logic        l2_ready;
    l2_line_t    l2_data;

    logic [31:0] vec_mem [0:3*MAX_VEC-1];   // op, address, expected per vector
    int          num_vec;
    int          cycle_limit;
    int          cycles;
    int          value_errors;
    int          other_errors;

    l1i_cache_top UUT (
        .clk         (clk),
        .nrst        (nrst),
        .read        (read),
        .addr        (addr),
        .flush       (flush),
        .stall       (stall),
        .instr       (instr),
        .instr_valid (instr_valid),
        .miss        (miss),
        .l2_read     (l2_read),
        .l2_req      (l2_req),
        .l2_ready    (l2_ready),
        .l2_data     (l2_data)
    );

    l2_mem_model u_l2 (
        .clk      (clk),
        .nrst     (nrst),
        .l2_read  (l2_read),
        .l2_req   (l2_req),
        .l2_ready (l2_ready),
        .l2_data  (l2_data)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #5 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if ((cycle_limit > 0) && (cycles >= cycle_limit))
        begin
            $display("timeout after %0d cycles, the cache stopped answering", cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // memory word for a word address
    function automatic instr_t expected_word(input fetch_addr_t a);
        logic [31:0] wa;
        wa = {4'h0, a};
        return (wa * 32'h9e3779b1) ^ 32'h5a5a0f0f;
    endfunction

    // line address is the word address without the offset
    function automatic l2_req_t expected_req(input fetch_addr_t a);
        return {a.tag, a.index};
    endfunction

    task automatic check_instr(input instr_t got, input instr_t exp);
        if (got !== exp)
        begin
            value_errors++;
            $display("ERROR t=%0t instr: got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic check_miss(input logic got, input logic exp);
        if (got !== exp)
        begin
            value_errors++;
            $display("ERROR t=%0t miss: got %b expected %b", $time, got, exp);
        end
    endtask

    task automatic check_req(input l2_req_t got, input l2_req_t exp);
        if (got !== exp)
        begin
            value_errors++;
            $display("ERROR t=%0t l2_req: got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic run_fetch(input fetch_addr_t a, input logic exp_hit);
        int      waited;
        int      miss_cnt;
        int      req_cnt;
        logic    read_prev;
        logic    done;
        l2_req_t req_seen;
        waited    = 0;
        miss_cnt  = 0;
        req_cnt   = 0;
        read_prev = 1'b0;
        done      = 1'b0;
        req_seen  = '0;
        @(negedge clk);
        read = 1'b1;
        addr = a;
        while (!done)
        begin
            @(negedge clk);
            waited++;
            if (!stall)
            begin
                other_errors++;
                $display("stall went low at t=%0t before the word for %h arrived", $time, a);
            end
            if (miss)
                miss_cnt++;
            if (l2_read && !read_prev)
            begin
                req_cnt++;
                req_seen = l2_req;
            end
            read_prev = l2_read;
            done      = instr_valid;
        end
        check_instr(instr, expected_word(a));
        check_miss(miss_cnt != 0, !exp_hit);
        if ((miss_cnt > 1) || (req_cnt != (exp_hit ? 0 : 1)))
        begin
            other_errors++;
            $display("fetch of %h gave %0d miss pulses and %0d line requests",
                     a, miss_cnt, req_cnt);
        end
        if (req_cnt == 1)
            check_req(req_seen, expected_req(a));
        if (exp_hit && (waited != 2))
        begin
            other_errors++;
            $display("hit on %h took %0d cycles instead of 2", a, waited);
        end
        @(negedge clk);     // addr held until back in idle
        read = 1'b0;
    endtask

    task automatic run_flush();
        @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
    endtask

    initial
    begin
        fetch_addr_t a;
        int          i;
        read         = 1'b0;
        addr         = '0;
        flush        = 1'b0;
        nrst         = 1'b0;
        cycles       = 0;
        cycle_limit  = 0;
        value_errors = 0;
        other_errors = 0;
        num_vec      = 0;
        for (i = 0; i < 3*MAX_VEC; i++)
            vec_mem[i] = 32'hffffffff;
        $readmemh("verification/l1i_vectors.txt", vec_mem);
        while ((num_vec < MAX_VEC) && (vec_mem[3*num_vec][3:0] != 4'hf))
            num_vec++;
        cycle_limit = 40 * num_vec + 100;

        repeat (5) @(posedge clk);
        @(negedge clk);
        nrst = 1'b1;
        if (stall || l2_read || instr_valid || miss)
        begin
            other_errors++;
            $display("outputs not low after reset");
        end

        for (i = 0; i < num_vec; i++)
        begin
            a = vec_mem[3*i+1][27:0];
            if (vec_mem[3*i][3:0] == 4'h1)
                run_flush();
            else
                run_fetch(a, vec_mem[3*i+2][0]);
        end

        repeat (2) @(negedge clk);
        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if ((value_errors == 0) && (other_errors == 0))
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: verification/l1i_assert.sv
module l1i_assert
(
    input logic clk,
    input logic nrst,
    input logic stall,
    input logic hit,
    input logic miss,
    input logic l2_read,
    input logic l2_ready,
    input logic refill
);

    // line request only while the core is held
    a_read_in_stall: assert property (@(posedge clk) disable iff (!nrst)
        $rose(l2_read) |-> stall)
        else $error("l2_read rose while stall was low");

    a_hit_miss_excl: assert property (@(posedge clk) disable iff (!nrst)
        !(hit && miss))
        else $error("hit and miss high in the same cycle");

    // every ready from level two is written one cycle later
    a_refill_after_ready: assert property (@(posedge clk) disable iff (!nrst)
        l2_ready |=> refill)
        else $error("refill missing one cycle after l2_ready");

endmodule

bind l1i_controller l1i_assert u_assert (
    .clk      (clk),
    .nrst     (nrst),
    .stall    (stall),
    .hit      (hit),
    .miss     (miss),
    .l2_read  (l2_read),
    .l2_ready (l2_ready),
    .refill   (refill)
);

// File: verification/l2_mem_model.sv
`include "icache_macros.svh"

module l2_mem_model
    import l2_bus_pkg::*;
(
    input  logic     clk,
    input  logic     nrst,
    input  logic     l2_read,
    input  l2_req_t  l2_req,
    output logic     l2_ready,
    output l2_line_t l2_data
);

    int unsigned delay;
    int unsigned seed_val;

    // word = (word address * golden ratio constant) xor fixed pattern
    function automatic logic [31:0] mix_word(input logic [25:0] line_addr, input logic [1:0] w);
        logic [31:0] wa;
        wa = {4'h0, line_addr, w};
        return (wa * 32'h9e3779b1) ^ 32'h5a5a0f0f;
    endfunction

    function automatic l2_line_t make_line(input l2_req_t req);
        l2_line_t line;
        for (int w = 0; w < `ICACHE_LINE_WORDS; w++)
            line[w] = mix_word(req, 2'(w));
        return line;
    endfunction

    initial
    begin
        seed_val = $urandom(32'hd6b6c020);
        l2_ready = 1'b0;
        l2_data  = '0;
        forever
        begin
            @(negedge clk);
            if (nrst && l2_read)
            begin
                delay = $urandom_range(6, 1);   // 1 to 6 cycles
                repeat (delay - 1)
                    @(negedge clk);
                l2_data  = make_line(l2_req);
                l2_ready = 1'b1;
                @(negedge clk);
                l2_ready = 1'b0;    // one cycle pulse
            end
        end
    end

endmodule

// File: rtl/l1i_cache_top.sv
module l1i_cache_top
    import icache_types_pkg::*, l2_bus_pkg::*;
(
    input  logic        clk,
    input  logic        nrst,
    input  logic        read,
    input  fetch_addr_t addr,
    input  logic        flush,
    output logic        stall,
    output instr_t      instr,
    output logic        instr_valid,
    output logic        miss,
    output logic        l2_read,
    output l2_req_t     l2_req,
    input  logic        l2_ready,
    input  l2_line_t    l2_data
);

    logic hit;
    logic refill;
    way_t way_sel;

    l1i_controller u_ctrl (
        .clk      (clk),
        .nrst     (nrst),
        .read     (read),
        .addr     (addr),
        .flush    (flush),
        .l2_ready (l2_ready),
        .stall    (stall),
        .miss     (miss),
        .hit      (hit),
        .l2_read  (l2_read),
        .l2_req   (l2_req),
        .refill   (refill),
        .way_sel  (way_sel)
    );

    l1i_data_array u_data (
        .clk      (clk),
        .nrst     (nrst),
        .index    (addr.index),
        .way_sel  (way_sel),
        .offset   (addr.offset),
        .l2_ready (l2_ready),
        .l2_data  (l2_data),
        .refill   (refill),
        .instr    (instr)
    );

    assign instr_valid = hit;   // word is valid during the hit pulse

endmodule

// File: rtl/l1i_data_array.sv
`include "icache_macros.svh"

module l1i_data_array
    import icache_types_pkg::*, l2_bus_pkg::*;
(
    input  logic     clk,
    input  logic     nrst,
    input  index_t   index,
    input  way_t     way_sel,
    input  offset_t  offset,
    input  logic     l2_ready,
    input  l2_line_t l2_data,
    input  logic     refill,
    output instr_t   instr
);

    localparam int LINES = `ICACHE_SETS * `ICACHE_WAYS;

    l2_line_t lines [0:LINES-1];
    l2_line_t line_buf;     // line held between ready and refill
    logic     line_pend;

    logic [`ICACHE_INDEX_W:0] slot;

    assign slot = {index, way_sel};

    always_ff @(posedge clk)
    begin
        if (l2_ready)
            line_buf <= l2_data;
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            line_pend <= 1'b0;
        else if (l2_ready)
            line_pend <= 1'b1;
        else if (refill)
            line_pend <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (refill && line_pend)
            lines[slot] <= line_buf;
    end

    // word select from the chosen way
    assign instr = lines[slot][offset];

endmodule

// File: rtl/l1i_controller.sv
`include "icache_macros.svh"

module l1i_controller
    import icache_types_pkg::*, l2_bus_pkg::*;
(
    input  logic        clk,
    input  logic        nrst,
    input  logic        read,
    input  fetch_addr_t addr,
    input  logic        flush,
    input  logic        l2_ready,
    output logic        stall,
    output logic        miss,
    output logic        hit,
    output logic        l2_read,
    output l2_req_t     l2_req,
    output logic        refill,
    output way_t        way_sel
);

    localparam int LINES = `ICACHE_SETS * `ICACHE_WAYS;

    ctrl_state_t state;
    ctrl_state_t next_state;

    tag_t               tag_arr [0:LINES-1];
    logic [LINES-1:0]   valid;
    lru_t               lru;

    way_t               way_q;
    logic               way_lock;   // way already chosen for this request
    logic               hit_q;
    logic               miss_q;
    logic               refill_q;
    logic               l2_read_q;

    logic [`ICACHE_INDEX_W:0] slot0;
    logic [`ICACHE_INDEX_W:0] slot1;
    logic [`ICACHE_INDEX_W:0] slot_w;
    logic               hit0;
    logic               hit1;
    logic               any_hit;
    way_t               victim;
    way_t               pick;

    assign slot0  = {addr.index, 1'b0};
    assign slot1  = {addr.index, 1'b1};
    assign slot_w = {addr.index, way_q};

    assign hit0    = valid[slot0] && (tag_arr[slot0] == addr.tag);
    assign hit1    = valid[slot1] && (tag_arr[slot1] == addr.tag);
    assign any_hit = hit0 || hit1;

    // empty way first, else lru
    assign victim = !valid[slot0] ? 1'b0 :
                    !valid[slot1] ? 1'b1 : lru[addr.index];
    assign pick   = hit0 ? 1'b0 : hit1 ? 1'b1 : victim;

    assign stall   = (state != st_idle);
    assign hit     = hit_q;
    assign miss    = miss_q;
    assign refill  = refill_q;
    assign l2_read = l2_read_q;
    assign way_sel = way_q;

    assign l2_req.l2_tag   = addr.tag[`ICACHE_TAG_W-1:2];
    assign l2_req.l2_index = {addr.tag[1:0], addr.index};

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            state <= st_idle;
        else
            state <= next_state;
    end

    always_comb
    begin
        case (state)
            st_idle:     next_state = read ? st_compare : st_idle;
            st_compare:  next_state = hit_q  ? st_idle :
                                      miss_q ? st_allocate : st_compare;
            st_allocate: next_state = l2_ready ? st_compare : st_allocate;
            default:     next_state = st_idle;
        endcase
    end

    // hit/miss flag, one cycle per compare
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            hit_q  <= 1'b0;
            miss_q <= 1'b0;
        end
        else if ((state == st_compare) && !hit_q && !miss_q)
        begin
            hit_q  <= any_hit;
            miss_q <= !any_hit;
        end
        else
        begin
            hit_q  <= 1'b0;
            miss_q <= 1'b0;
        end
    end

    // way is locked on the first compare, kept through the refill
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            way_q    <= 1'b0;
            way_lock <= 1'b0;
        end
        else if (state == st_idle)
            way_lock <= 1'b0;
        else if ((state == st_compare) && !way_lock)
        begin
            way_q    <= pick;
            way_lock <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            lru <= '0;
        else if ((state == st_compare) && hit_q)
            lru[addr.index] <= ~way_q;  // other way is next victim
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            valid <= '0;
        else if ((state == st_idle) && flush)
            valid <= '0;
        else if ((state == st_allocate) && l2_ready)
            valid[slot_w] <= 1'b1;
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            for (int i = 0; i < LINES; i++)
                tag_arr[i] <= '0;
        end
        else if ((state == st_allocate) && l2_ready)
            tag_arr[slot_w] <= addr.tag;
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            refill_q  <= 1'b0;
            l2_read_q <= 1'b0;
        end
        else
        begin
            refill_q  <= (state == st_allocate) && l2_ready;
            // drops with the ready so no second line request goes out
            l2_read_q <= (state == st_allocate) && !l2_ready;
        end
    end

endmodule

// File: rtl/l2_bus_pkg.sv
`include "icache_macros.svh"

package l2_bus_pkg;

    typedef logic [`L2_TAG_W-1:0]   l2_tag_t;
    typedef logic [`L2_INDEX_W-1:0] l2_index_t;

    // line address toward level two
    // l2_index holds the low two L1 tag bits above the L1 set index
    typedef struct packed {
        l2_tag_t   l2_tag;
        l2_index_t l2_index;
    } l2_req_t;

    // word 0 sits in the low bits
    typedef logic [`ICACHE_LINE_WORDS-1:0][`ICACHE_WORD_W-1:0] l2_line_t;

endpackage

// File: rtl/icache_types_pkg.sv
`include "icache_macros.svh"

package icache_types_pkg;

    typedef logic [`ICACHE_TAG_W-1:0]    tag_t;
    typedef logic [`ICACHE_INDEX_W-1:0]  index_t;
    typedef logic [`ICACHE_OFFSET_W-1:0] offset_t;

    // word address from the core, 28 bits
    typedef struct packed {
        tag_t    tag;
        index_t  index;
        offset_t offset;
    } fetch_addr_t;

    typedef logic way_t;

    // one bit per set, points at the next victim way
    typedef logic [`ICACHE_SETS-1:0] lru_t;

    typedef logic [`ICACHE_WORD_W-1:0] instr_t;

    typedef enum logic [1:0] {
        st_idle     = 2'b00,
        st_compare  = 2'b01,
        st_allocate = 2'b11
    } ctrl_state_t;

endpackage

// File: include/icache_macros.svh
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// fetch address split, word addressed
`define ICACHE_TAG_W        24
`define ICACHE_INDEX_W      2
`define ICACHE_OFFSET_W     2

// geometry
`define ICACHE_SETS         4
`define ICACHE_WAYS         2
`define ICACHE_LINE_WORDS   4
`define ICACHE_WORD_W       32

// level-two line address, same 26 bits regrouped
`define L2_INDEX_W          4
`define L2_TAG_W            22

`endif
